// File: mesh_pkg.sv
package mesh_pkg;

        // Grid position of a router, x counts columns and y counts rows
        typedef logic [1:0] coord_t;

        typedef logic [2:0] port_t;

        // Router ports
        // North faces row y-1 and south faces row y+1
        localparam port_t port_north = 3'd0;
        localparam port_t port_east  = 3'd1;
        localparam port_t port_south = 3'd2;
        localparam port_t port_west  = 3'd3;
        localparam port_t port_local = 3'd4;

        localparam int num_ports = 5;

endpackage

// File: noc_pkg.sv
package noc_pkg;

        import mesh_pkg::*;

        localparam int flit_w = 35;

        typedef enum logic [1:0] {
                kind_head      = 2'd0,
                kind_body      = 2'd1,
                kind_tail      = 2'd2,
                kind_head_tail = 2'd3
        } flit_kind_t;

        localparam int head_payload_w = flit_w - $bits(flit_kind_t) - 2 * $bits(coord_t);
        localparam int body_payload_w = flit_w - $bits(flit_kind_t);

        // Head carries the destination, everything after it is payload only
        typedef struct packed {
                flit_kind_t                kind;
                coord_t                    dst_x;
                coord_t                    dst_y;
                logic [head_payload_w-1:0] payload;
        } head_flit_t;

        typedef struct packed {
                flit_kind_t                kind;
                logic [body_payload_w-1:0] payload;
        } body_flit_t;

        // Kind sits in the top bits of both views
        typedef union packed {
                head_flit_t head;
                body_flit_t body;
        } flit_t;

        function automatic logic is_head(flit_t f);
                return f.head.kind inside {kind_head, kind_head_tail};
        endfunction

        function automatic logic is_tail(flit_t f);
                return f.body.kind inside {kind_tail, kind_head_tail};
        endfunction

endpackage

// File: noc_input_buffer.sv
`timescale 1ns/1ns

module noc_input_buffer
        import mesh_pkg::*;
        import noc_pkg::*;
#(
        parameter int     buffer_depth = 2,
        parameter coord_t my_x         = '0,
        parameter coord_t my_y         = '0
) (
        input  logic  clk,
        input  logic  reset,
        input  flit_t in_flit,
        input  logic  in_valid,
        output logic  in_ready,
        output flit_t head_flit,
        output logic  head_valid,
        output port_t head_port,
        input  logic  head_pop
);

        localparam int ptr_w = (buffer_depth > 1) ? $clog2(buffer_depth) : 1;
        localparam int cnt_w = $clog2(buffer_depth + 1);

        flit_t            mem [buffer_depth];
        logic [ptr_w-1:0] wr_ptr;
        logic [ptr_w-1:0] rd_ptr;
        logic [cnt_w-1:0] count;
        port_t            route_q;
        port_t            xy_port;
        logic             push;
        logic             pop;

        function automatic logic [ptr_w-1:0] ptr_next(logic [ptr_w-1:0] p);
                if (p == ptr_w'(buffer_depth - 1)) begin
                        return '0;
                end
                return p + 1'b1;
        endfunction

        assign in_ready   = (count != cnt_w'(buffer_depth));
        assign head_valid = (count != '0);
        assign head_flit  = mem[rd_ptr];
        assign push       = in_valid && in_ready;
        assign pop        = head_pop && head_valid;

        // XY order, column first and then row
        always_comb begin
                if (head_flit.head.dst_x > my_x) begin
                        xy_port = port_east;
                end else if (head_flit.head.dst_x < my_x) begin
                        xy_port = port_west;
                end else if (head_flit.head.dst_y > my_y) begin
                        xy_port = port_south;
                end else if (head_flit.head.dst_y < my_y) begin
                        xy_port = port_north;
                end else begin
                        xy_port = port_local;
                end
        end

        // Body and tail flits follow the port their head took
        assign head_port = is_head(head_flit) ? xy_port : route_q;

        always_ff @(posedge clk) begin
                if (push) begin
                        mem[wr_ptr] <= in_flit;
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        wr_ptr  <= '0;
                        rd_ptr  <= '0;
                        count   <= '0;
                        route_q <= port_local;
                end else begin
                        if (push) begin
                                wr_ptr <= ptr_next(wr_ptr);
                        end
                        if (pop) begin
                                rd_ptr <= ptr_next(rd_ptr);
                                if (is_head(head_flit)) begin
                                        route_q <= xy_port;
                                end
                        end
                        count <= count + cnt_w'(push) - cnt_w'(pop);
                end
        end

endmodule

// File: noc_switch_alloc.sv
`timescale 1ns/1ns

module noc_switch_alloc
        import mesh_pkg::*;
(
        input  logic                 clk,
        input  logic                 reset,
        input  logic [num_ports-1:0] request,
        input  logic                 tail_done,
        output logic [num_ports-1:0] grant
);

        localparam int idx_w = $clog2(num_ports);

        logic             locked;
        logic [idx_w-1:0] lock_idx;
        logic [idx_w-1:0] prio;
        logic [idx_w-1:0] win_idx;
        logic [idx_w-1:0] sel_idx;
        logic             found;
        logic             active;

        // First requester at or after the priority pointer
        always_comb begin
                int k;
                found   = 1'b0;
                win_idx = prio;
                for (int i = 0; i < num_ports; i++) begin
                        k = int'(prio) + i;
                        if (k >= num_ports) begin
                                k = k - num_ports;
                        end
                        if (!found && request[k]) begin
                                found   = 1'b1;
                                win_idx = idx_w'(k);
                        end
                end
        end

        assign sel_idx = locked ? lock_idx : win_idx;
        assign active  = locked || found;

        always_comb begin
                grant = '0;
                if (active) begin
                        grant[sel_idx] = 1'b1;
                end
        end

        // A granted head keeps the output until its tail has gone
        always_ff @(posedge clk) begin
                if (reset) begin
                        locked   <= 1'b0;
                        lock_idx <= '0;
                        prio     <= '0;
                end else if (active) begin
                        if (tail_done) begin
                                locked <= 1'b0;
                                if (sel_idx == idx_w'(num_ports - 1)) begin
                                        prio <= '0;
                                end else begin
                                        prio <= sel_idx + 1'b1;
                                end
                        end else begin
                                locked   <= 1'b1;
                                lock_idx <= sel_idx;
                        end
                end
        end

endmodule

// File: noc_router.sv
`timescale 1ns/1ns

module noc_router
        import mesh_pkg::*;
        import noc_pkg::*;
#(
        parameter int     buffer_depth = 2,
        parameter coord_t my_x         = '0,
        parameter coord_t my_y         = '0
) (
        input  logic                 clk,
        input  logic                 reset,
        input  flit_t                in_flit [num_ports],
        input  logic [num_ports-1:0] in_valid,
        output logic [num_ports-1:0] in_ready,
        output flit_t                out_flit [num_ports],
        output logic [num_ports-1:0] out_valid,
        input  logic [num_ports-1:0] out_ready
);

        flit_t                buf_flit [num_ports];
        logic [num_ports-1:0] buf_valid;
        port_t                buf_port [num_ports];
        logic [num_ports-1:0] buf_pop;
        // Indexed by output port, one bit per input buffer
        logic [num_ports-1:0] request [num_ports];
        logic [num_ports-1:0] grant [num_ports];
        logic [num_ports-1:0] xfer;
        logic [num_ports-1:0] tail_done;

        for (genvar p = 0; p < num_ports; p++) begin : g_port
                noc_input_buffer #(
                        .buffer_depth(buffer_depth),
                        .my_x        (my_x),
                        .my_y        (my_y)
                ) in_buf_i (
                        .clk       (clk),
                        .reset     (reset),
                        .in_flit   (in_flit[p]),
                        .in_valid  (in_valid[p]),
                        .in_ready  (in_ready[p]),
                        .head_flit (buf_flit[p]),
                        .head_valid(buf_valid[p]),
                        .head_port (buf_port[p]),
                        .head_pop  (buf_pop[p])
                );

                noc_switch_alloc out_alloc_i (
                        .clk      (clk),
                        .reset    (reset),
                        .request  (request[p]),
                        .tail_done(tail_done[p]),
                        .grant    (grant[p])
                );
        end

        always_comb begin
                for (int o = 0; o < num_ports; o++) begin
                        for (int i = 0; i < num_ports; i++) begin
                                request[o][i] = buf_valid[i] && (buf_port[i] == port_t'(o));
                        end
                end
        end

        // Crossbar
        always_comb begin
                for (int o = 0; o < num_ports; o++) begin
                        out_flit[o]  = '0;
                        out_valid[o] = 1'b0;
                        for (int i = 0; i < num_ports; i++) begin
                                if (grant[o][i]) begin
                                        out_flit[o]  = buf_flit[i];
                                        out_valid[o] = request[o][i];
                                end
                        end
                end
        end

        always_comb begin
                for (int o = 0; o < num_ports; o++) begin
                        xfer[o]      = out_valid[o] && out_ready[o];
                        tail_done[o] = xfer[o] && is_tail(out_flit[o]);
                end
        end

        always_comb begin
                buf_pop = '0;
                for (int o = 0; o < num_ports; o++) begin
                        for (int i = 0; i < num_ports; i++) begin
                                if (xfer[o] && grant[o][i]) begin
                                        buf_pop[i] = 1'b1;
                                end
                        end
                end
        end

endmodule

// File: noc_mesh.sv
`timescale 1ns/1ns

module noc_mesh
        import mesh_pkg::*;
        import noc_pkg::*;
#(
        parameter int    mesh_width   = 3,
        parameter int    mesh_height  = 3,
        parameter int    buffer_depth = 2,
        localparam int   num_nodes    = mesh_width * mesh_height
) (
        input  logic                 clk,
        input  logic                 reset,
        input  flit_t                local_in_flit [num_nodes],
        input  logic [num_nodes-1:0] local_in_valid,
        output logic [num_nodes-1:0] local_in_ready,
        output flit_t                local_out_flit [num_nodes],
        output logic [num_nodes-1:0] local_out_valid,
        input  logic [num_nodes-1:0] local_out_ready
);

        flit_t                node_in_flit [num_nodes][num_ports];
        logic [num_ports-1:0] node_in_valid [num_nodes];
        logic [num_ports-1:0] node_in_ready [num_nodes];
        flit_t                node_out_flit [num_nodes][num_ports];
        logic [num_ports-1:0] node_out_valid [num_nodes];
        logic [num_ports-1:0] node_out_ready [num_nodes];

        for (genvar y = 0; y < mesh_height; y++) begin : g_row
                for (genvar x = 0; x < mesh_width; x++) begin : g_col
                        localparam int n = y * mesh_width + x;

                        noc_router #(
                                .buffer_depth(buffer_depth),
                                .my_x        (coord_t'(x)),
                                .my_y        (coord_t'(y))
                        ) router_i (
                                .clk      (clk),
                                .reset    (reset),
                                .in_flit  (node_in_flit[n]),
                                .in_valid (node_in_valid[n]),
                                .in_ready (node_in_ready[n]),
                                .out_flit (node_out_flit[n]),
                                .out_valid(node_out_valid[n]),
                                .out_ready(node_out_ready[n])
                        );

                        assign node_in_flit[n][port_local]   = local_in_flit[n];
                        assign node_in_valid[n][port_local]  = local_in_valid[n];
                        assign local_in_ready[n]             = node_in_ready[n][port_local];
                        assign local_out_flit[n]             = node_out_flit[n][port_local];
                        assign local_out_valid[n]            = node_out_valid[n][port_local];
                        assign node_out_ready[n][port_local] = local_out_ready[n];

                        // Mesh ports 0 to 3, the facing port is two steps round
                        for (genvar p = 0; p < 4; p++) begin : g_link
                                localparam int op = (p + 2) % 4;
                                localparam bit has_nb =
                                        (p == port_north) ? (y > 0) :
                                        (p == port_east)  ? (x < mesh_width - 1) :
                                        (p == port_south) ? (y < mesh_height - 1) :
                                                            (x > 0);
                                localparam int nb =
                                        (p == port_north) ? n - mesh_width :
                                        (p == port_east)  ? n + 1 :
                                        (p == port_south) ? n + mesh_width :
                                                            n - 1;

                                if (has_nb) begin : g_nb
                                        assign node_in_flit[n][p]   = node_out_flit[nb][op];
                                        assign node_in_valid[n][p]  = node_out_valid[nb][op];
                                        assign node_out_ready[n][p] = node_in_ready[nb][op];
                                end else begin : g_edge
                                        assign node_in_flit[n][p]   = '0;
                                        assign node_in_valid[n][p]  = 1'b0;
                                        assign node_out_ready[n][p] = 1'b0;
                                end
                        end
                end
        end

endmodule

// File: tb_noc_mesh.sv
`timescale 1ns/1ns

module tb_noc_mesh
        import mesh_pkg::*;
        import noc_pkg::*;
();

        localparam int mesh_w    = 3;
        localparam int nodes     = mesh_w * 3;
        localparam int num_fixed = 9;

        typedef struct packed {
                int   src;
                int   dst;
                int   len;
                int   start;
                logic stall;
        } pkt_row_t;

        // src, dst, flits, start cycle, stall destination
        pkt_row_t fixed_rows [num_fixed] = '{
                '{0, 8, 4, 300, 1'b0},
                '{2, 6, 3, 300, 1'b0},
                '{1, 4, 5, 400, 1'b0},
                '{3, 4, 5, 400, 1'b0},
                '{5, 4, 5, 400, 1'b0},
                '{7, 4, 5, 400, 1'b0},
                '{8, 0, 6, 600, 1'b1},
                '{6, 0, 4, 600, 1'b1},
                '{4, 2, 2, 600, 1'b1}
        };

        logic             clk;
        logic             reset;
        flit_t            local_in_flit [nodes];
        logic [nodes-1:0] local_in_valid;
        logic [nodes-1:0] local_in_ready;
        flit_t            local_out_flit [nodes];
        logic [nodes-1:0] local_out_valid;
        logic [nodes-1:0] local_out_ready;

        pkt_row_t         rows [$];
        flit_t            send_q [nodes][$];
        int               send_at [nodes][$];
        // One queue per source and destination pair
        flit_t            exp_q [nodes*nodes][$];
        logic [nodes-1:0] stall_mask;
        logic [nodes-1:0] held_valid;
        flit_t            held_flit [nodes];
        logic [nodes-1:0] pkt_open;
        int               open_src [nodes];
        logic [31:0]      lfsr;
        logic             active;
        int               cycle;
        int               last_rx;
        int               outstanding;
        int               total_flits;
        int               limit;

        noc_mesh #(
                .mesh_width  (mesh_w),
                .mesh_height (3),
                .buffer_depth(2)
        ) noc_mesh_i (
                .clk            (clk),
                .reset          (reset),
                .local_in_flit  (local_in_flit),
                .local_in_valid (local_in_valid),
                .local_in_ready (local_in_ready),
                .local_out_flit (local_out_flit),
                .local_out_valid(local_out_valid),
                .local_out_ready(local_out_ready)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        function automatic logic [31:0] lfsr_next(logic [31:0] s);
                if (s[0]) begin
                        return (s >> 1) ^ 32'h8020_0003;
                end
                return s >> 1;
        endfunction

        function automatic logic all_sent();
                for (int n = 0; n < nodes; n++) begin
                        if (send_q[n].size() > 0) begin
                                return 1'b0;
                        end
                end
                return 1'b1;
        endfunction

        task automatic random_bits(input int n, output logic [31:0] bits);
                bits = '0;
                for (int i = 0; i < n; i++) begin
                        bits = {bits[30:0], lfsr[0]};
                        lfsr = lfsr_next(lfsr);
                end
        endtask

        task automatic stop_run(input string msg);
                $display("%s", msg);
                $display("FAIL: see errors above");
                $fatal(1);
        endtask

        // Upper payload bits hold source id and a running sequence number
        task automatic build_traffic();
                pkt_row_t    r;
                flit_t       f;
                logic [31:0] bits;
                int          seq;
                seq = 0;
                for (int s = 0; s < nodes; s++) begin
                        for (int d = 0; d < nodes; d++) begin
                                r = '{s, d, 1, 0, 1'b0};
                                if (s != d) begin
                                        rows.push_back(r);
                                end
                        end
                end
                for (int i = 0; i < num_fixed; i++) begin
                        rows.push_back(fixed_rows[i]);
                end
                stall_mask  = '0;
                total_flits = 0;
                foreach (rows[i]) begin
                        r = rows[i];
                        if (r.stall) begin
                                stall_mask[r.dst] = 1'b1;
                        end
                        for (int k = 0; k < r.len; k++) begin
                                f = '0;
                                if (k == 0) begin
                                        random_bits(15, bits);
                                        f.head.kind    = (r.len == 1) ? kind_head_tail : kind_head;
                                        f.head.dst_x   = coord_t'(r.dst % mesh_w);
                                        f.head.dst_y   = coord_t'(r.dst / mesh_w);
                                        f.head.payload = {4'(r.src), 10'(seq), bits[14:0]};
                                end else begin
                                        random_bits(19, bits);
                                        f.body.kind    = (k == r.len - 1) ? kind_tail : kind_body;
                                        f.body.payload = {4'(r.src), 10'(seq), bits[18:0]};
                                end
                                send_q[r.src].push_back(f);
                                send_at[r.src].push_back(r.start);
                                exp_q[r.src * nodes + r.dst].push_back(f);
                                seq++;
                                total_flits++;
                        end
                end
        endtask

        task automatic check_delivery(input int d, input flit_t f);
                logic first;
                logic last;
                int   src;
                int   idx;
                first = (f.head.kind == kind_head) || (f.head.kind == kind_head_tail);
                last  = (f.body.kind == kind_tail) || (f.body.kind == kind_head_tail);
                src   = first ? int'(f.head.payload[28:25]) : int'(f.body.payload[32:29]);
                idx   = src * nodes + d;
                assert (src < nodes && exp_q[idx].size() > 0) else
                        stop_run($sformatf("Fail at %0t ns: unexpected flit %h at node %0d",
                                $time, f, d));
                assert (f == exp_q[idx][0]) else
                        stop_run($sformatf("Fail at %0t ns: node %0d got %h, expected %h",
                                $time, d, f, exp_q[idx][0]));
                void'(exp_q[idx].pop_front());
                outstanding--;
                if (first) begin
                        assert (!pkt_open[d]) else
                                stop_run($sformatf("Fail at %0t ns: head cut into packet at node %0d",
                                        $time, d));
                        pkt_open[d] = !last;
                        open_src[d] = src;
                end else begin
                        assert (pkt_open[d] && open_src[d] == src) else
                                stop_run($sformatf("Fail at %0t ns: interleaved flit at node %0d",
                                        $time, d));
                        pkt_open[d] = !last;
                end
        endtask

        // Handshakes complete on the rising edge
        always @(posedge clk) begin
                if (reset) begin
                        active     = 1'b0;
                        cycle      = 0;
                        last_rx    = 0;
                        held_valid = '0;
                        pkt_open   = '0;
                end else begin
                        active = 1'b1;
                        cycle  = cycle + 1;
                        for (int n = 0; n < nodes; n++) begin
                                if (local_in_valid[n] && local_in_ready[n]) begin
                                        void'(send_q[n].pop_front());
                                        void'(send_at[n].pop_front());
                                end
                                if (held_valid[n]) begin
                                        assert (local_out_valid[n] &&
                                                local_out_flit[n] == held_flit[n]) else
                                                stop_run($sformatf("Fail at %0t ns: %s %0d",
                                                        $time, "stalled flit changed at node", n));
                                end
                                held_valid[n] = local_out_valid[n] && !local_out_ready[n];
                                held_flit[n]  = local_out_flit[n];
                                if (local_out_valid[n] && local_out_ready[n]) begin
                                        check_delivery(n, local_out_flit[n]);
                                        last_rx = cycle;
                                end
                        end
                end
        end

        always @(negedge clk) begin
                logic [31:0] bits;
                for (int n = 0; n < nodes; n++) begin
                        if (active && send_q[n].size() > 0 && cycle >= send_at[n][0]) begin
                                local_in_flit[n]  = send_q[n][0];
                                local_in_valid[n] = 1'b1;
                        end else begin
                                local_in_flit[n]  = '0;
                                local_in_valid[n] = 1'b0;
                        end
                        if (active && stall_mask[n]) begin
                                random_bits(1, bits);
                                local_out_ready[n] = bits[0];
                        end else begin
                                local_out_ready[n] = 1'b1;
                        end
                end
        end

        initial begin
                reset           = 1'b1;
                local_in_valid  = '0;
                local_out_ready = '1;
                held_valid      = '0;
                pkt_open        = '0;
                active          = 1'b0;
                cycle           = 0;
                last_rx         = 0;
                lfsr            = 32'h11e2;
                for (int n = 0; n < nodes; n++) begin
                        local_in_flit[n] = '0;
                        held_flit[n]     = '0;
                        open_src[n]      = 0;
                end
                build_traffic();
                outstanding = total_flits;
                limit       = 500 + 40 * total_flits;
                repeat (10) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;
                @(posedge clk);
                assert (local_out_valid == '0 && local_in_ready == '1) else
                        stop_run($sformatf("Fail at %0t ns: ports not idle after reset", $time));
                // Every source empty and no arrival for long enough to expose a lost flit
                while (!all_sent() || cycle - last_rx < 40) begin
                        @(negedge clk);
                        if (cycle > limit) begin
                                stop_run($sformatf("Timeout: %0d flits undelivered after %0d cycles",
                                        outstanding, cycle));
                        end
                end
                for (int i = 0; i < nodes * nodes; i++) begin
                        assert (exp_q[i].size() == 0) else
                                stop_run($sformatf("Fail at %0t ns: pair %0d not drained", $time, i));
                end
                assert (local_out_valid == '0) else
                        stop_run($sformatf("Fail at %0t ns: output valid left high", $time));
                $display("PASS: all tests");
                $finish;
        end

endmodule

// File: list.f
mesh_pkg.sv
noc_pkg.sv
noc_input_buffer.sv
noc_switch_alloc.sv
noc_router.sv
noc_mesh.sv
tb_noc_mesh.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_noc_mesh -f list.f -o sim_noc_mesh &&
./obj_dir/sim_noc_mesh || exit 1
